//--- hw/dcache_geom_pkg.sv
// L1 data cache geometry
package dcache_geom_pkg;

  // organisation
  localparam int NUM_WAYS       = 2;
  localparam int NUM_SETS       = 16;
  localparam int NUM_RD_PORTS   = 2;

  // data widths
  localparam int WORD_WIDTH     = 32;
  localparam int LINE_WIDTH     = 128;
  localparam int BYTES_PER_WORD = WORD_WIDTH / 8;

  // one bank per word of a line
  localparam int NUM_BANKS      = LINE_WIDTH / WORD_WIDTH;

  // address fields
  localparam int TAG_WIDTH      = 8;
  localparam int IDX_WIDTH      = $clog2(NUM_SETS);
  localparam int OFF_WIDTH      = $clog2(LINE_WIDTH / 8);

  // offset split, upper bits pick the bank
  localparam int BYTE_OFF_WIDTH = $clog2(BYTES_PER_WORD);
  localparam int BANK_SEL_WIDTH = OFF_WIDTH - BYTE_OFF_WIDTH;

  // read port numbering
  localparam int PORT_SEL_WIDTH = $clog2(NUM_RD_PORTS);

endpackage

//--- hw/dcache_port_pkg.sv
// L1 data cache port types
package dcache_port_pkg;

  import dcache_geom_pkg::*;

  // address fields
  typedef logic [TAG_WIDTH-1:0]      tag_t;
  typedef logic [IDX_WIDTH-1:0]      idx_t;
  typedef logic [OFF_WIDTH-1:0]      off_t;
  typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;

  // data and byte enables
  typedef logic [WORD_WIDTH-1:0]     word_t;
  typedef logic [BYTES_PER_WORD-1:0] word_be_t;
  typedef word_t [NUM_BANKS-1:0]     line_t;
  typedef logic [LINE_WIDTH/8-1:0]   line_be_t;

  // one bit per way or per read port
  typedef logic [NUM_WAYS-1:0]       way_vec_t;
  typedef logic [NUM_RD_PORTS-1:0]   port_vec_t;
  typedef logic [PORT_SEL_WIDTH-1:0] port_sel_t;

endpackage

//--- hw/dcache_bank_if.sv
// Data bank request bus
interface dcache_bank_if;

  // one request per word bank
  logic [dcache_geom_pkg::NUM_BANKS-1:0] bank_req;
  logic [dcache_geom_pkg::NUM_BANKS-1:0] bank_we;
  dcache_port_pkg::idx_t [dcache_geom_pkg::NUM_BANKS-1:0] bank_idx;

  // set: write data from the cacheline, clear: from the word port
  logic [dcache_geom_pkg::NUM_BANKS-1:0] line_sel;

  // byte enables of every way in every bank
  dcache_port_pkg::word_be_t [dcache_geom_pkg::NUM_BANKS-1:0][dcache_geom_pkg::NUM_WAYS-1:0]
    way_be;

  modport ctrl (
    output bank_req,
    output bank_we,
    output bank_idx,
    output line_sel,
    output way_be
  );

  modport bank (
    input bank_req,
    input bank_we,
    input bank_idx,
    input line_sel,
    input way_be
  );

endinterface

//--- hw/dcache_tag_if.sv
// Tag and valid array access bus
interface dcache_tag_if;

  // ways touched this cycle
  dcache_port_pkg::way_vec_t tag_req;
  logic                      tag_we;
  dcache_port_pkg::idx_t     tag_addr;
  // valid bits written with the tag
  dcache_port_pkg::way_vec_t tag_wvld;

  modport ctrl (
    output tag_req,
    output tag_we,
    output tag_addr,
    output tag_wvld
  );

  modport tags (
    input tag_req,
    input tag_we,
    input tag_addr,
    input tag_wvld
  );

endinterface

//--- hw/dcache_bank_ctrl.sv
// Read arbiter and bank steering
module dcache_bank_ctrl (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  dcache_port_pkg::port_vec_t                                  rd_req_i,
  input  dcache_port_pkg::port_vec_t                                  rd_prio_i,
  input  dcache_port_pkg::port_vec_t                                  rd_tag_only_i,
  input  dcache_port_pkg::idx_t [dcache_geom_pkg::NUM_RD_PORTS-1:0]   rd_idx_i,
  input  dcache_port_pkg::off_t [dcache_geom_pkg::NUM_RD_PORTS-1:0]   rd_off_i,
  input  logic                                                        wr_cl_vld_i,
  input  dcache_port_pkg::way_vec_t                                   wr_cl_we_i,
  input  dcache_port_pkg::idx_t                                       wr_cl_idx_i,
  input  dcache_port_pkg::off_t                                       wr_cl_off_i,
  input  dcache_port_pkg::line_be_t                                   wr_cl_be_i,
  input  dcache_port_pkg::way_vec_t                                   wr_vld_bits_i,
  input  dcache_port_pkg::way_vec_t                                   wr_req_i,
  input  dcache_port_pkg::idx_t                                       wr_idx_i,
  input  dcache_port_pkg::off_t                                       wr_off_i,
  input  dcache_port_pkg::word_be_t                                   wr_be_i,
  output dcache_port_pkg::port_vec_t                                  rd_ack_o,
  output logic                                                        wr_ack_o,
  output dcache_port_pkg::port_sel_t                                  cmp_sel_o,
  output logic                                                        cmp_en_o,
  output dcache_port_pkg::bank_sel_t                                  cmp_off_o,
  dcache_bank_if.ctrl                                                 bank,
  dcache_tag_if.ctrl                                                  tags
);

  import dcache_geom_pkg::*;
  import dcache_port_pkg::*;

  port_vec_t rd_req_prio, rd_req_masked;
  port_sel_t rr_q, rd_sel;
  logic      rd_gnt_vld, rd_acked, rd_data_acc;
  bank_sel_t rd_bank, wr_bank;

  ////////////////////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////////////////////

  // high priority requests hide the low priority ones
  assign rd_req_prio   = rd_req_i & rd_prio_i;
  assign rd_req_masked = (|rd_req_prio) ? rd_req_prio : rd_req_i;

  // first request at or after the round-robin pointer
  always_comb begin : p_arb
    int p;
    rd_gnt_vld = 1'b0;
    rd_sel     = rr_q;
    for (int i = 0; i < NUM_RD_PORTS; i++) begin
      p = (int'(rr_q) + i) % NUM_RD_PORTS;
      if (!rd_gnt_vld && rd_req_masked[p]) begin
        rd_gnt_vld = 1'b1;
        rd_sel     = port_sel_t'(p);
      end
    end
  end

  // a cacheline write holds off every read
  assign rd_acked    = rd_gnt_vld & ~wr_cl_vld_i;
  assign rd_data_acc = rd_acked & ~rd_tag_only_i[rd_sel];

  always_comb begin
    rd_ack_o = '0;
    if (rd_acked) begin
      rd_ack_o[rd_sel] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bank and tag steering
  ////////////////////////////////////////////////////////////////////////////

  assign rd_bank = rd_off_i[rd_sel][OFF_WIDTH-1:BYTE_OFF_WIDTH];
  assign wr_bank = wr_off_i[OFF_WIDTH-1:BYTE_OFF_WIDTH];

  always_comb begin : p_bank_req
    bank.bank_req = '0;
    bank.bank_we  = '0;
    bank.bank_idx = '{default: wr_idx_i};
    bank.line_sel = '0;
    bank.way_be   = '0;
    wr_ack_o      = 1'b0;
    if (wr_cl_vld_i) begin
      // the line write owns all banks
      bank.bank_req = '1;
      bank.bank_we  = '1;
      bank.bank_idx = '{default: wr_cl_idx_i};
      bank.line_sel = '1;
      for (int k = 0; k < NUM_BANKS; k++) begin
        for (int j = 0; j < NUM_WAYS; j++) begin
          if (wr_cl_we_i[j]) begin
            bank.way_be[k][j] = wr_cl_be_i[k*BYTES_PER_WORD +: BYTES_PER_WORD];
          end
        end
      end
    end else begin
      if (rd_data_acc) begin
        bank.bank_req[rd_bank] = 1'b1;
        bank.bank_idx[rd_bank] = rd_idx_i[rd_sel];
      end
      // word write waits only on a data read to the same bank
      if (|wr_req_i && !(rd_data_acc && rd_bank == wr_bank)) begin
        wr_ack_o               = 1'b1;
        bank.bank_req[wr_bank] = 1'b1;
        bank.bank_we[wr_bank]  = 1'b1;
        for (int j = 0; j < NUM_WAYS; j++) begin
          bank.way_be[wr_bank][j] = wr_req_i[j] ? wr_be_i : '0;
        end
      end
    end
  end

  // tag read of all ways on a grant or tag write on a line fill
  assign tags.tag_req  = wr_cl_vld_i ? wr_cl_we_i : {NUM_WAYS{rd_acked}};
  assign tags.tag_we   = wr_cl_vld_i;
  assign tags.tag_addr = wr_cl_vld_i ? wr_cl_idx_i : rd_idx_i[rd_sel];
  assign tags.tag_wvld = wr_vld_bits_i;

  // compare stage registers and round-robin pointer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q      <= '0;
      cmp_sel_o <= '0;
      cmp_en_o  <= 1'b0;
      cmp_off_o <= '0;
    end else begin
      if (rd_acked) begin
        rr_q <= port_sel_t'((int'(rd_sel) + 1) % NUM_RD_PORTS);
      end
      cmp_sel_o <= rd_sel;
      cmp_en_o  <= rd_acked;
      cmp_off_o <= rd_bank;
    end
  end

endmodule

//--- hw/dcache_data_banks.sv
// Word-banked data arrays
module dcache_data_banks (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  dcache_bank_if.bank                    bank,
  input  dcache_port_pkg::line_t         wr_cl_data_i,
  input  dcache_port_pkg::word_t         wr_data_i,
  output dcache_port_pkg::word_t [dcache_geom_pkg::NUM_BANKS-1:0][dcache_geom_pkg::NUM_WAYS-1:0]
                                         bank_rdata_o
);

  import dcache_geom_pkg::*;
  import dcache_port_pkg::*;

  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_bank
    // one row holds this word of every way
    word_t [NUM_WAYS-1:0] mem_q [NUM_SETS];
    word_t                wdata;

    // line slice on a fill, word port otherwise
    assign wdata = bank.line_sel[k] ? wr_cl_data_i[k] : wr_data_i;

    always_ff @(posedge clk_i) begin
      if (bank.bank_req[k] && bank.bank_we[k]) begin
        for (int j = 0; j < NUM_WAYS; j++) begin
          for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (bank.way_be[k][j][b]) begin
              mem_q[bank.bank_idx[k]][j][8*b +: 8] <= wdata[8*b +: 8];
            end
          end
        end
      end
    end

    // registered readout of the addressed row
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        bank_rdata_o[k] <= '0;
      end else if (bank.bank_req[k] && !bank.bank_we[k]) begin
        bank_rdata_o[k] <= mem_q[bank.bank_idx[k]];
      end
    end
  end

endmodule

//--- hw/dcache_tag_array.sv
// Tag and valid storage
module dcache_tag_array (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  dcache_tag_if.tags                                            tags,
  input  dcache_port_pkg::tag_t                                 wr_cl_tag_i,
  output dcache_port_pkg::tag_t [dcache_geom_pkg::NUM_WAYS-1:0] tag_rdata_o,
  output dcache_port_pkg::way_vec_t                             vld_rdata_o
);

  import dcache_geom_pkg::*;
  import dcache_port_pkg::*;

  tag_t [NUM_WAYS-1:0] tag_q [NUM_SETS];
  way_vec_t            vld_q [NUM_SETS];

  // tags, read back one cycle after the request
  always_ff @(posedge clk_i) begin
    if (tags.tag_we) begin
      for (int j = 0; j < NUM_WAYS; j++) begin
        if (tags.tag_req[j]) begin
          tag_q[tags.tag_addr][j] <= wr_cl_tag_i;
        end
      end
    end else if (|tags.tag_req) begin
      tag_rdata_o <= tag_q[tags.tag_addr];
    end
  end

  // valid bits start cleared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q       <= '{default: '0};
      vld_rdata_o <= '0;
    end else if (tags.tag_we) begin
      for (int j = 0; j < NUM_WAYS; j++) begin
        if (tags.tag_req[j]) begin
          vld_q[tags.tag_addr][j] <= tags.tag_wvld[j];
        end
      end
    end else if (|tags.tag_req) begin
      vld_rdata_o <= vld_q[tags.tag_addr];
    end
  end

endmodule

//--- hw/dcache_hit_select.sv
// Tag compare and word readout
module dcache_hit_select (
  input  dcache_port_pkg::tag_t [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_tag_i,
  input  dcache_port_pkg::port_sel_t                                cmp_sel_i,
  input  logic                                                      cmp_en_i,
  input  dcache_port_pkg::bank_sel_t                                cmp_off_i,
  input  dcache_port_pkg::tag_t [dcache_geom_pkg::NUM_WAYS-1:0]     tag_rdata_i,
  input  dcache_port_pkg::way_vec_t                                 vld_rdata_i,
  input  dcache_port_pkg::word_t [dcache_geom_pkg::NUM_BANKS-1:0][dcache_geom_pkg::NUM_WAYS-1:0]
                                                                    bank_rdata_i,
  output dcache_port_pkg::way_vec_t                                 rd_vld_bits_o,
  output dcache_port_pkg::way_vec_t                                 rd_hit_oh_o,
  output dcache_port_pkg::word_t                                    rd_data_o
);

  import dcache_geom_pkg::*;
  import dcache_port_pkg::*;

  // tag of the port granted last cycle
  tag_t                 rd_tag;
  word_t [NUM_WAYS-1:0] way_word;

  assign rd_tag        = rd_tag_i[cmp_sel_i];
  assign rd_vld_bits_o = vld_rdata_i;

  for (genvar j = 0; j < NUM_WAYS; j++) begin : gen_way
    assign rd_hit_oh_o[j] = cmp_en_i & vld_rdata_i[j] & (tag_rdata_i[j] == rd_tag);
    assign way_word[j]    = bank_rdata_i[cmp_off_i][j];
  end

  // lowest hitting way wins, way 0 on a miss
  always_comb begin
    rd_data_o = way_word[0];
    for (int j = NUM_WAYS - 1; j >= 0; j--) begin
      if (rd_hit_oh_o[j]) begin
        rd_data_o = way_word[j];
      end
    end
  end

endmodule

//--- hw/dcache_mem.sv
// L1 data cache memory block
module dcache_mem (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  // read ports
  input  dcache_port_pkg::port_vec_t                                rd_req_i,
  input  dcache_port_pkg::port_vec_t                                rd_prio_i,
  input  dcache_port_pkg::port_vec_t                                rd_tag_only_i,
  input  dcache_port_pkg::idx_t [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_idx_i,
  input  dcache_port_pkg::off_t [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_off_i,
  input  dcache_port_pkg::tag_t [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_tag_i,
  output dcache_port_pkg::port_vec_t                                rd_ack_o,
  output dcache_port_pkg::way_vec_t                                 rd_vld_bits_o,
  output dcache_port_pkg::way_vec_t                                 rd_hit_oh_o,
  output dcache_port_pkg::word_t                                    rd_data_o,
  // cacheline write
  input  logic                                                      wr_cl_vld_i,
  input  dcache_port_pkg::way_vec_t                                 wr_cl_we_i,
  input  dcache_port_pkg::tag_t                                     wr_cl_tag_i,
  input  dcache_port_pkg::idx_t                                     wr_cl_idx_i,
  input  dcache_port_pkg::off_t                                     wr_cl_off_i,
  input  dcache_port_pkg::line_t                                    wr_cl_data_i,
  input  dcache_port_pkg::line_be_t                                 wr_cl_be_i,
  input  dcache_port_pkg::way_vec_t                                 wr_vld_bits_i,
  // word write
  input  dcache_port_pkg::way_vec_t                                 wr_req_i,
  output logic                                                      wr_ack_o,
  input  dcache_port_pkg::idx_t                                     wr_idx_i,
  input  dcache_port_pkg::off_t                                     wr_off_i,
  input  dcache_port_pkg::word_t                                    wr_data_i,
  input  dcache_port_pkg::word_be_t                                 wr_be_i
);

  import dcache_geom_pkg::*;
  import dcache_port_pkg::*;

  port_sel_t                            cmp_sel;
  logic                                 cmp_en;
  bank_sel_t                            cmp_off;
  tag_t  [NUM_WAYS-1:0]                 tag_rdata;
  way_vec_t                             vld_rdata;
  word_t [NUM_BANKS-1:0][NUM_WAYS-1:0]  bank_rdata;

  dcache_bank_if bank_bus ();
  dcache_tag_if  tag_bus ();

  dcache_bank_ctrl u_bank_ctrl (
    .clk_i, .rst_ni, .rd_req_i, .rd_prio_i, .rd_tag_only_i, .rd_idx_i, .rd_off_i,
    .wr_cl_vld_i, .wr_cl_we_i, .wr_cl_idx_i, .wr_cl_off_i, .wr_cl_be_i, .wr_vld_bits_i,
    .wr_req_i, .wr_idx_i, .wr_off_i, .wr_be_i, .rd_ack_o, .wr_ack_o,
    .cmp_sel_o (cmp_sel),
    .cmp_en_o  (cmp_en),
    .cmp_off_o (cmp_off),
    .bank      (bank_bus.ctrl),
    .tags      (tag_bus.ctrl)
  );

  dcache_data_banks u_data_banks (
    .clk_i, .rst_ni, .wr_cl_data_i, .wr_data_i,
    .bank         (bank_bus.bank),
    .bank_rdata_o (bank_rdata)
  );

  dcache_tag_array u_tag_array (
    .clk_i, .rst_ni, .wr_cl_tag_i,
    .tags        (tag_bus.tags),
    .tag_rdata_o (tag_rdata),
    .vld_rdata_o (vld_rdata)
  );

  dcache_hit_select u_hit_select (
    .rd_tag_i, .rd_vld_bits_o, .rd_hit_oh_o, .rd_data_o,
    .cmp_sel_i    (cmp_sel),
    .cmp_en_i     (cmp_en),
    .cmp_off_i    (cmp_off),
    .tag_rdata_i  (tag_rdata),
    .vld_rdata_i  (vld_rdata),
    .bank_rdata_i (bank_rdata)
  );

endmodule

//--- verification/dcache_mem_chk.sv
// Cache memory checker
module dcache_mem_chk (
  input logic                             clk_i, rst_ni,
  input logic                             wr_cl_vld_i, wr_ack_o,
  input dcache_port_pkg::port_vec_t       rd_req_i, rd_prio_i, rd_tag_only_i, rd_ack_o,
  input dcache_port_pkg::idx_t [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_idx_i,
  input dcache_port_pkg::off_t [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_off_i,
  input dcache_port_pkg::tag_t [dcache_geom_pkg::NUM_RD_PORTS-1:0] rd_tag_i,
  input dcache_port_pkg::way_vec_t        rd_vld_bits_o, rd_hit_oh_o,
  input dcache_port_pkg::way_vec_t        wr_cl_we_i, wr_vld_bits_i, wr_req_i,
  input dcache_port_pkg::word_t           rd_data_o, wr_data_i,
  input dcache_port_pkg::tag_t            wr_cl_tag_i,
  input dcache_port_pkg::idx_t            wr_cl_idx_i, wr_idx_i,
  input dcache_port_pkg::off_t            wr_off_i,
  input dcache_port_pkg::line_t           wr_cl_data_i,
  input dcache_port_pkg::line_be_t        wr_cl_be_i,
  input dcache_port_pkg::word_be_t        wr_be_i
);

  import dcache_geom_pkg::*;
  import dcache_port_pkg::*;

  int err_cnt = 0;

  // shadow of tags, valid bits and line words
  tag_t     sh_tag  [NUM_SETS][NUM_WAYS];
  word_t    sh_data [NUM_SETS][NUM_WAYS][NUM_BANKS];
  way_vec_t sh_vld  [NUM_SETS];

  port_sel_t            rr_q, gnt_port, cmp_port_q;
  port_vec_t            req_m, exp_ack;
  bank_sel_t            gnt_bank, wr_bank;
  logic                 exp_wr_ack, cmp_vld_q, cmp_data_q;
  way_vec_t             cmp_vbits_q, exp_hit;
  tag_t  [NUM_WAYS-1:0] cmp_tags_q;
  word_t [NUM_WAYS-1:0] cmp_words_q;
  word_t                exp_word;

  always_comb begin
    req_m    = (|(rd_req_i & rd_prio_i)) ? (rd_req_i & rd_prio_i) : rd_req_i;
    // two ports, so the other one when the pointer's port is idle
    gnt_port = req_m[rr_q] ? rr_q : ~rr_q;
    exp_ack  = '0;
    if (|req_m && !wr_cl_vld_i) begin
      exp_ack[gnt_port] = 1'b1;
    end
    gnt_bank   = rd_off_i[gnt_port][OFF_WIDTH-1:BYTE_OFF_WIDTH];
    wr_bank    = wr_off_i[OFF_WIDTH-1:BYTE_OFF_WIDTH];
    exp_wr_ack = |wr_req_i && !wr_cl_vld_i &&
                 !(|exp_ack && !rd_tag_only_i[gnt_port] && gnt_bank == wr_bank);
    for (int j = 0; j < NUM_WAYS; j++) begin
      exp_hit[j] = cmp_vld_q && cmp_vbits_q[j] && (cmp_tags_q[j] == rd_tag_i[cmp_port_q]);
    end
    exp_word = cmp_words_q[0];
    for (int j = NUM_WAYS - 1; j >= 0; j--) begin
      if (exp_hit[j]) begin
        exp_word = cmp_words_q[j];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q      <= '0;
      cmp_vld_q <= 1'b0;
      sh_vld    <= '{default: '0};
    end else begin
      if (|exp_ack) begin
        rr_q <= ~gnt_port;
      end
      for (int j = 0; j < NUM_WAYS; j++) begin
        if (wr_cl_vld_i && wr_cl_we_i[j]) begin
          sh_vld[wr_cl_idx_i][j] <= wr_vld_bits_i[j];
        end
      end
      cmp_vld_q <= |exp_ack;
    end
  end

  // capture what a read granted now must see, writes land at the same edge
  always_ff @(posedge clk_i) begin
    cmp_port_q  <= gnt_port;
    cmp_data_q  <= ~rd_tag_only_i[gnt_port];
    cmp_vbits_q <= sh_vld[rd_idx_i[gnt_port]];
    for (int j = 0; j < NUM_WAYS; j++) begin
      cmp_tags_q[j]  <= sh_tag[rd_idx_i[gnt_port]][j];
      cmp_words_q[j] <= sh_data[rd_idx_i[gnt_port]][j][gnt_bank];
      if (wr_cl_vld_i && wr_cl_we_i[j]) begin
        sh_tag[wr_cl_idx_i][j] <= wr_cl_tag_i;
        for (int k = 0; k < NUM_BANKS; k++) begin
          for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (wr_cl_be_i[k*BYTES_PER_WORD+b]) begin
              sh_data[wr_cl_idx_i][j][k][8*b +: 8] <= wr_cl_data_i[k][8*b +: 8];
            end
          end
        end
      end
      if (wr_ack_o && wr_req_i[j]) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
          if (wr_be_i[b]) begin
            sh_data[wr_idx_i][j][wr_bank][8*b +: 8] <= wr_data_i[8*b +: 8];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  a_rd_ack: assert property (@(posedge clk_i) disable iff (!rst_ni) rd_ack_o == exp_ack)
    else begin
      $error("ERR %0t rd_ack_o exp %b got %b", $time, $sampled(exp_ack), $sampled(rd_ack_o));
      err_cnt++;
    end

  a_wr_ack: assert property (@(posedge clk_i) disable iff (!rst_ni) wr_ack_o == exp_wr_ack)
    else begin
      $error("ERR %0t wr_ack_o exp %b got %b", $time, $sampled(exp_wr_ack), $sampled(wr_ack_o));
      err_cnt++;
    end

  a_hit: assert property (@(posedge clk_i) disable iff (!rst_ni) rd_hit_oh_o == exp_hit)
    else begin
      $error("ERR %0t rd_hit_oh_o exp %b got %b", $time, $sampled(exp_hit), $sampled(rd_hit_oh_o));
      err_cnt++;
    end

  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(rd_hit_oh_o))
    else begin
      $error("hit vector at %0t has more than one way set: %b", $time, $sampled(rd_hit_oh_o));
      err_cnt++;
    end

  a_vld_bits: assert property (@(posedge clk_i) disable iff (!rst_ni)
                               cmp_vld_q |-> rd_vld_bits_o == cmp_vbits_q)
    else begin
      $error("ERR %0t rd_vld_bits_o exp %b got %b", $time, $sampled(cmp_vbits_q),
             $sampled(rd_vld_bits_o));
      err_cnt++;
    end

  a_rd_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
                              cmp_data_q && |exp_hit |-> rd_data_o == exp_word)
    else begin
      $error("ERR %0t rd_data_o exp %h got %h", $time, $sampled(exp_word), $sampled(rd_data_o));
      err_cnt++;
    end

endmodule

//--- verification/tb_clkgen.sv
// Testbench clock and reset
module tb_clkgen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release in a low phase, away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- verification/tb_dcache_mem.sv
// Cache memory testbench
module tb_dcache_mem;

  import dcache_geom_pkg::*;
  import dcache_port_pkg::*;

  localparam int          CLK_PERIOD   = 40;
  localparam int          RST_CYCLES   = 4;
  localparam int          IDLE_CYCLES  = 4;
  localparam int          FILL_SETS    = 8;
  localparam int          RAND_CYCLES  = 400;
  localparam int          DRAIN_CYCLES = 8;
  localparam int          TEST_CYCLES  = RST_CYCLES + IDLE_CYCLES + FILL_SETS * NUM_WAYS +
                                         RAND_CYCLES + DRAIN_CYCLES;
  localparam logic [31:0] SEED         = 32'h16c31be3;

  logic                     clk_i, rst_ni, wr_cl_vld_i, wr_ack_o;
  port_vec_t                rd_req_i, rd_prio_i, rd_tag_only_i, rd_ack_o;
  idx_t [NUM_RD_PORTS-1:0]  rd_idx_i;
  off_t [NUM_RD_PORTS-1:0]  rd_off_i;
  tag_t [NUM_RD_PORTS-1:0]  rd_tag_i;
  way_vec_t                 rd_vld_bits_o, rd_hit_oh_o, wr_cl_we_i, wr_vld_bits_i, wr_req_i;
  word_t                    rd_data_o, wr_data_i;
  tag_t                     wr_cl_tag_i;
  idx_t                     wr_cl_idx_i, wr_idx_i;
  off_t                     wr_cl_off_i, wr_off_i;
  line_t                    wr_cl_data_i;
  line_be_t                 wr_cl_be_i;
  word_be_t                 wr_be_i;

  logic [31:0] seed;
  // tag last written to each set and way
  tag_t        line_tag [NUM_SETS][NUM_WAYS];

  tb_clkgen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clkgen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  dcache_mem u_dcache_mem (.*);

  bind dcache_mem dcache_mem_chk u_chk (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] rand_word();
    seed = xorshift32(seed);
    return seed;
  endfunction

  task automatic start_fill(input int fill_set, input int fill_way, input logic vld);
    tag_t tag;
    tag = tag_t'(rand_word());
    // two ways of a set never share a tag
    if (tag == line_tag[fill_set][1-fill_way]) begin
      tag = tag ^ tag_t'(1);
    end
    line_tag[fill_set][fill_way] = tag;
    wr_cl_vld_i          = 1'b1;
    wr_cl_we_i           = '0;
    wr_cl_we_i[fill_way] = 1'b1;
    wr_cl_tag_i          = tag;
    wr_cl_idx_i          = idx_t'(fill_set);
    wr_cl_off_i          = off_t'(rand_word());
    wr_cl_be_i           = '1;
    wr_vld_bits_i        = {NUM_WAYS{vld}};
    for (int k = 0; k < NUM_BANKS; k++) begin
      wr_cl_data_i[k] = rand_word();
    end
  endtask

  // one clock of stimulus; a negative fill_set means no forced fill
  task automatic run_cycle(input logic issue, input int fill_set, input int fill_way);
    port_vec_t   ack_seen;
    logic        wr_ack_seen;
    logic [31:0] r;
    @(negedge clk_i);
    ack_seen    = rd_ack_o;
    wr_ack_seen = wr_ack_o;
    @(posedge clk_i);
    #2;
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      r = rand_word();
      if (ack_seen[p]) begin
        // mostly the stored tag of one way, now and then a random one
        rd_tag_i[p] = (r[1:0] != 2'b00) ? line_tag[rd_idx_i[p]][r[2]] : tag_t'(r[15:8]);
        rd_req_i[p] = 1'b0;
      end
      if (issue && !rd_req_i[p] && r[3]) begin
        rd_req_i[p]      = 1'b1;
        rd_prio_i[p]     = (r[5:4] == 2'b00);
        rd_tag_only_i[p] = (r[7:6] == 2'b00);
        rd_idx_i[p]      = idx_t'(r[18:16]);
        rd_off_i[p]      = off_t'(r[23:20]);
      end
    end
    r = rand_word();
    if (wr_ack_seen) begin
      wr_req_i = '0;
    end
    if (issue && wr_req_i == '0 && r[0]) begin
      wr_req_i[r[3]] = 1'b1;
      if (r[2:1] == 2'b00) begin
        wr_req_i = '1;
      end
      wr_idx_i  = idx_t'(r[6:4]);
      wr_off_i  = off_t'(r[11:8]);
      wr_be_i   = r[15:12];
      wr_data_i = rand_word();
    end
    wr_cl_vld_i = 1'b0;
    wr_cl_we_i  = '0;
    r = rand_word();
    if (fill_set >= 0) begin
      start_fill(fill_set, fill_way, 1'b1);
    end else if (issue && r[3:0] == 4'h0) begin
      start_fill(int'(r[6:4]), int'(r[7]), r[9:8] != 2'b00);
    end
  endtask

  initial begin
    seed     = SEED;
    line_tag = '{default: '0};
    {rd_req_i, rd_prio_i, rd_tag_only_i, rd_idx_i, rd_off_i, rd_tag_i} = '0;
    {wr_cl_vld_i, wr_cl_we_i, wr_cl_tag_i, wr_cl_idx_i, wr_cl_off_i} = '0;
    {wr_cl_data_i, wr_cl_be_i, wr_vld_bits_i} = '0;
    {wr_req_i, wr_idx_i, wr_off_i, wr_data_i, wr_be_i} = '0;
    @(posedge rst_ni);
    repeat (IDLE_CYCLES) run_cycle(1'b0, -1, 0);
    // back-to-back line fills while reads and word writes wait
    for (int s = 0; s < FILL_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        run_cycle(1'b1, s, w);
      end
    end
    repeat (RAND_CYCLES) run_cycle(1'b1, -1, 0);
    repeat (DRAIN_CYCLES) run_cycle(1'b0, -1, 0);
    $display("run complete, %0d assertion failures", u_dcache_mem.u_chk.err_cnt);
    if (u_dcache_mem.u_chk.err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(CLK_PERIOD * (TEST_CYCLES + 100));
    $display("timeout: the run did not end within %0d clock cycles", TEST_CYCLES + 100);
    $display("Test failed");
    $finish;
  end

endmodule

//--- dcache_mem.f
hw/dcache_geom_pkg.sv
hw/dcache_port_pkg.sv
hw/dcache_bank_if.sv
hw/dcache_tag_if.sv
hw/dcache_bank_ctrl.sv
hw/dcache_data_banks.sv
hw/dcache_tag_array.sv
hw/dcache_hit_select.sv
hw/dcache_mem.sv
verification/dcache_mem_chk.sv
verification/tb_clkgen.sv
verification/tb_dcache_mem.sv
